// ==== verilog.f ====
pkt_pkg.sv
mem_rd_if.sv
pkt_writer.sv
pkt_mem.sv
load_adapter.sv
pkt_load_top.sv
tb_pkt_load_checks.sv
tb_pkt_load.sv

// ==== Bender.yml ====
package:
  name: pkt_load

sources:
  - files:
      - pkt_pkg.sv
      - mem_rd_if.sv
      - pkt_writer.sv
      - pkt_mem.sv
      - load_adapter.sv
      - pkt_load_top.sv
  - target: test
    files:
      - tb_pkt_load_checks.sv
      - tb_pkt_load.sv

// ==== tb_pkt_load.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_pkt_load;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 16;
    localparam int N_WORDS1     = 37;
    localparam int N_WORDS2     = 10;
    localparam int N_RANDOM     = 200;
    // All loads issued over the run
    localparam int N_LOADS      = 320;
    localparam int RESULT_WAIT  = 4 * pkt_pkg::LOAD_LAT;
    localparam int TIMEOUT_NS   = (N_WORDS1 + N_WORDS2 + N_LOADS + 100) * CLK_PERIOD * 2;

    logic                                clk;
    logic                                rst;
    logic                                cap_stb;
    logic [pkt_pkg::CAP_WIDTH-1:0]       cap_data;
    logic                                cap_end;
    logic                                load_stb;
    logic [pkt_pkg::BYTE_ADDR_WIDTH-1:0] load_addr;
    pkt_pkg::xfer_size_e                 load_size;
    logic [pkt_pkg::PLEN_WIDTH-1:0]      pkt_len;
    logic [pkt_pkg::LOAD_WIDTH-1:0]      load_data;
    logic                                load_vld;
    logic                                load_fault;
    logic                                timed_out;

    // Reference copy of the captured packet
    logic [7:0]  pkt_bytes [4096];
    int          model_len;
    logic [31:0] lcg_state = 32'h7d57c507;

    pkt_load_top u_pkt_load_top (
        .clk          (clk),
        .rst          (rst),
        .cap_stb_i    (cap_stb),
        .cap_data_i   (cap_data),
        .cap_end_i    (cap_end),
        .load_stb_i   (load_stb),
        .load_addr_i  (load_addr),
        .load_size_i  (load_size),
        .pkt_len_o    (pkt_len),
        .load_data_o  (load_data),
        .load_vld_o   (load_vld),
        .load_fault_o (load_fault)
    );

    tb_pkt_load_checks #(.TIMEOUT_NS(TIMEOUT_NS)) u_checks (
        .clk          (clk),
        .rst          (rst),
        .load_stb_i   (load_stb),
        .load_data_i  (load_data),
        .load_vld_i   (load_vld),
        .load_fault_i (load_fault),
        .timeout_o    (timed_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Fault in bit 32; bytes big-endian, zero-padded on the left
    function automatic logic [32:0] predict_load(input int addr, input logic [1:0] size);
        int          nbytes;
        logic        fault;
        logic [31:0] data;
        nbytes = (size == 2'd0) ? 4 : (size == 2'd1) ? 2 : (size == 2'd2) ? 1 : 0;
        fault  = (nbytes == 0) || (addr + nbytes > model_len) || (addr % 8 + nbytes > 8);
        data   = '0;
        if (!fault) begin
            for (int i = 0; i < nbytes; i++) begin
                data = {data[23:0], pkt_bytes[addr + i]};
            end
        end
        return {fault, data};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // End strobe rides on the last word
    task automatic capture_packet(input int n_words);
        logic [31:0] word;
        for (int i = 0; i < n_words; i++) begin
            word = lcg_next();
            for (int b = 0; b < 4; b++) begin
                pkt_bytes[4 * i + b] = word[31 - 8 * b -: 8];
            end
            cap_stb  = 1'b1;
            cap_data = word;
            cap_end  = (i == n_words - 1);
            next_cycle();
        end
        cap_stb   = 1'b0;
        cap_end   = 1'b0;
        model_len = 4 * n_words;
    endtask

    task automatic issue_load(input int addr, input logic [1:0] size);
        logic [32:0] exp;
        exp = predict_load(addr, size);
        u_checks.push_expected(exp[31:0], exp[32]);
        load_stb  = 1'b1;
        load_addr = addr[pkt_pkg::BYTE_ADDR_WIDTH-1:0];
        load_size = pkt_pkg::xfer_size_e'(size);
        next_cycle();
    endtask

    task automatic wait_results();
        int cycles;
        load_stb = 1'b0;
        cycles   = 0;
        while (u_checks.pending() != 0 && cycles < RESULT_WAIT) begin
            next_cycle();
            cycles++;
        end
        if (u_checks.pending() != 0) begin
            u_checks.report_failure("Load results still missing after the wait");
        end
    endtask

    task automatic random_loads(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = lcg_next();
            // Some addresses land past the packet, about one size in sixteen is illegal
            issue_load(int'(r[30:20]) % (model_len + 16),
                       (r[23:20] == 4'hf) ? 2'd3 : r[17:16] % 2'd3);
        end
        wait_results();
    endtask

    initial begin
        rst       = 1'b0;
        cap_stb   = 1'b0;
        cap_data  = '0;
        cap_end   = 1'b0;
        load_stb  = 1'b0;
        load_addr = '0;
        load_size = pkt_pkg::XFER_W;
        model_len = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b1;

        u_checks.compare_value("load_vld_o after reset", {31'd0, load_vld}, 32'd0);
        u_checks.compare_value("pkt_len_o after reset", pkt_len, 32'd0);
        capture_packet(N_WORDS1);
        u_checks.compare_value("pkt_len_o", pkt_len, 32'd148);
        u_checks.finish_test("reset_length");

        for (int a = 0; a < model_len; a += 4) issue_load(a, pkt_pkg::XFER_W);
        for (int a = 0; a < 32; a += 2) issue_load(a, pkt_pkg::XFER_H);
        for (int a = 0; a < 16; a++) issue_load(a, pkt_pkg::XFER_B);
        wait_results();
        u_checks.finish_test("aligned");

        // Every offset of one memory word, all three sizes
        for (int off = 0; off < pkt_pkg::WORD_BYTES; off++) begin
            issue_load(72 + off, pkt_pkg::XFER_W);
            issue_load(72 + off, pkt_pkg::XFER_H);
            issue_load(72 + off, pkt_pkg::XFER_B);
        end
        wait_results();
        u_checks.finish_test("unaligned");

        // Packet ends at byte 148
        issue_load(140, pkt_pkg::XFER_W);
        issue_load(144, pkt_pkg::XFER_W);
        issue_load(145, pkt_pkg::XFER_W);
        issue_load(148, pkt_pkg::XFER_W);
        issue_load(146, pkt_pkg::XFER_H);
        issue_load(147, pkt_pkg::XFER_H);
        issue_load(147, pkt_pkg::XFER_B);
        issue_load(148, pkt_pkg::XFER_B);
        for (int a = 0; a <= 148; a += 48) issue_load(a, 2'd3);
        wait_results();
        u_checks.finish_test("length_bound");

        random_loads(N_RANDOM);
        u_checks.finish_test("back_to_back");

        capture_packet(N_WORDS2);
        u_checks.compare_value("pkt_len_o second packet", pkt_len, 32'd40);
        for (int a = 0; a < model_len; a += 4) issue_load(a, pkt_pkg::XFER_W);
        issue_load(38, pkt_pkg::XFER_H);
        issue_load(39, pkt_pkg::XFER_B);
        issue_load(40, pkt_pkg::XFER_W);
        issue_load(44, pkt_pkg::XFER_W);
        issue_load(100, pkt_pkg::XFER_B);
        wait_results();
        u_checks.finish_test("second_packet");

        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 u_checks.tests_run, u_checks.tests_failed, u_checks.total_errors);
        if (u_checks.tests_failed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        @(posedge timed_out);
        $display("Watchdog expired at %0t before all tests finished", $time);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_pkt_load_checks.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_pkt_load_checks #(
    parameter int unsigned TIMEOUT_NS = 100000
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           load_stb_i,
    input  wire logic [pkt_pkg::LOAD_WIDTH-1:0] load_data_i,
    input  wire logic                           load_vld_i,
    input  wire logic                           load_fault_i,
    output logic                                timeout_o
);

    // Expected results in issue order
    logic [pkt_pkg::LOAD_WIDTH-1:0] exp_data_q [$];
    logic                           exp_fault_q [$];
    logic [pkt_pkg::LOAD_WIDTH-1:0] exp_data;
    logic                           exp_fault;

    // Per-test and overall counts
    int unsigned test_checks = 0;
    int unsigned test_errors = 0;
    int unsigned tests_run = 0;
    int unsigned tests_failed = 0;
    int unsigned total_errors = 0;

    task automatic push_expected(input logic [31:0] data, input logic fault);
        exp_data_q.push_back(data);
        exp_fault_q.push_back(fault);
    endtask

    function automatic int pending();
        return exp_data_q.size();
    endfunction

    task automatic report_failure(input string msg);
        test_errors++;
        $display("%s at %0t", msg, $time);
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        test_checks++;
        assert (got === exp) else begin
            test_errors++;
            $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // One line per test, counters restart for the next one
    task automatic finish_test(input string name);
        $display("%s: %0d checks, %0d errors, %s", name, test_checks, test_errors,
                 (test_errors == 0) ? "ok" : "FAILED");
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    // Result strobe rises just after edge E0+LOAD_LAT and is sampled at the edge after that
    vld_latency: assert property (
        @(posedge clk) disable iff (!rst)
        load_vld_i == $past(load_stb_i, pkt_pkg::LOAD_LAT + 1)
    ) else begin
        test_errors++;
        $display("Error at %0t: load_vld_o not %0d cycles after load_stb_i",
                 $time, pkt_pkg::LOAD_LAT);
    end

    // Faulted loads carry zero data
    fault_zero: assert property (
        @(posedge clk) disable iff (!rst)
        load_vld_i && load_fault_i |-> load_data_i == '0
    ) else begin
        test_errors++;
        $display("Error at %0t: faulted load has data %0h", $time, load_data_i);
    end

    // Result registers are stable at the falling edge
    always @(negedge clk) begin
        if (rst && load_vld_i) begin
            if (exp_data_q.size() == 0) begin
                report_failure("Load result arrived with no load outstanding");
            end else begin
                exp_data  = exp_data_q.pop_front();
                exp_fault = exp_fault_q.pop_front();
                compare_value("load_fault_o", {31'd0, load_fault_i}, {31'd0, exp_fault});
                compare_value("load_data_o", load_data_i, exp_data);
            end
        end
    end

    // Watchdog
    initial begin
        timeout_o = 1'b0;
        #(TIMEOUT_NS);
        timeout_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== pkt_load_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module pkt_load_top (
    input  wire logic                                clk,
    input  wire logic                                rst,

    // Capture stream
    input  wire logic                                cap_stb_i,
    input  wire logic [pkt_pkg::CAP_WIDTH-1:0]       cap_data_i,
    input  wire logic                                cap_end_i,

    // CPU loads
    input  wire logic                                load_stb_i,
    input  wire logic [pkt_pkg::BYTE_ADDR_WIDTH-1:0] load_addr_i,
    input  wire pkt_pkg::xfer_size_e                 load_size_i,

    // Packet length and load results
    output logic [pkt_pkg::PLEN_WIDTH-1:0]           pkt_len_o,
    output logic [pkt_pkg::LOAD_WIDTH-1:0]           load_data_o,
    output logic                                     load_vld_o,
    output logic                                     load_fault_o
);

    // Writer to memory
    logic                                wr_en;
    logic [1:0]                          wr_lane;
    logic [pkt_pkg::WORD_ADDR_WIDTH-1:0] wr_addr;
    logic [pkt_pkg::CAP_WIDTH-1:0]       wr_data;

    // Adapter to memory
    mem_rd_if rd_bus ();

    pkt_writer u_pkt_writer (
        .clk        (clk),
        .rst        (rst),
        .cap_stb_i  (cap_stb_i),
        .cap_data_i (cap_data_i),
        .cap_end_i  (cap_end_i),
        .wr_en_o    (wr_en),
        .wr_lane_o  (wr_lane),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data),
        .byte_len_o (pkt_len_o)
    );

    pkt_mem u_pkt_mem (
        .clk       (clk),
        .rst       (rst),
        .wr_en_i   (wr_en),
        .wr_lane_i (wr_lane),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd        (rd_bus.responder)
    );

    // Length check uses the latched packet length
    load_adapter u_load_adapter (
        .clk          (clk),
        .rst          (rst),
        .load_stb_i   (load_stb_i),
        .load_addr_i  (load_addr_i),
        .load_size_i  (load_size_i),
        .byte_len_i   (pkt_len_o),
        .rd           (rd_bus.requester),
        .load_data_o  (load_data_o),
        .load_vld_o   (load_vld_o),
        .load_fault_o (load_fault_o)
    );

endmodule

`default_nettype wire

// ==== load_adapter.sv ====
`timescale 1ns/100ps
`default_nettype none

module load_adapter (
    input  wire logic                                clk,
    input  wire logic                                rst,

    // Load request from the filter CPU
    input  wire logic                                load_stb_i,
    input  wire logic [pkt_pkg::BYTE_ADDR_WIDTH-1:0] load_addr_i,
    input  wire pkt_pkg::xfer_size_e                 load_size_i,
    input  wire logic [pkt_pkg::PLEN_WIDTH-1:0]      byte_len_i,

    // Packet memory read port
    mem_rd_if.requester                              rd,

    // Load result, LOAD_LAT cycles after the strobe
    output logic [pkt_pkg::LOAD_WIDTH-1:0]           load_data_o,
    output logic                                     load_vld_o,
    output logic                                     load_fault_o
);

    // Per-load context kept alongside the memory read
    typedef struct packed {
        logic [pkt_pkg::OFFSET_WIDTH-1:0] offset;
        pkt_pkg::xfer_size_e              size;
        logic                             fault;
    } load_ctx_t;

    logic [pkt_pkg::OFFSET_WIDTH-1:0] req_off;
    pkt_pkg::span_t                   req_bytes;
    pkt_pkg::span_t                   span_end;
    logic [pkt_pkg::PLEN_WIDTH:0]     end_addr;
    logic                             size_bad;
    logic                             req_fault;

    // Registered read request
    logic                                rd_stb_q;
    logic [pkt_pkg::WORD_ADDR_WIDTH-1:0] rd_addr_q;
    load_ctx_t                           req_ctx;

    // Context shift pipeline matching the memory latency
    load_ctx_t                           ctx_pipe [pkt_pkg::MEM_LAT];
    load_ctx_t                           ctx_out;

    logic [pkt_pkg::WORD_WIDTH-1:0]      shifted;
    logic [pkt_pkg::LOAD_WIDTH-1:0]      selected;
    logic [pkt_pkg::LOAD_WIDTH-1:0]      resized;

    assign req_off = load_addr_i[pkt_pkg::OFFSET_WIDTH-1:0];

    // Bytes covered by the load
    always_comb begin
        size_bad = 1'b0;
        case (load_size_i)
            pkt_pkg::XFER_W: req_bytes = pkt_pkg::span_t'(4);
            pkt_pkg::XFER_H: req_bytes = pkt_pkg::span_t'(2);
            pkt_pkg::XFER_B: req_bytes = pkt_pkg::span_t'(1);
            default: begin
                req_bytes = '0;
                size_bad  = 1'b1;
            end
        endcase
    end

    // One past the last byte, compared against the packet length
    assign end_addr = {{(pkt_pkg::PLEN_WIDTH + 1 - pkt_pkg::BYTE_ADDR_WIDTH){1'b0}}, load_addr_i}
                    + {{(pkt_pkg::PLEN_WIDTH - pkt_pkg::OFFSET_WIDTH){1'b0}}, req_bytes};

    // Span past byte 7 would need a second memory word
    assign span_end = {1'b0, req_off} + req_bytes;

    assign req_fault = size_bad
                     || (end_addr > {1'b0, byte_len_i})
                     || (span_end > pkt_pkg::span_t'(pkt_pkg::WORD_BYTES));

    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_stb_q <= 1'b0;
        end else begin
            rd_stb_q <= load_stb_i;
        end
    end

    always_ff @(posedge clk) begin
        rd_addr_q      <= load_addr_i[pkt_pkg::BYTE_ADDR_WIDTH-1:pkt_pkg::OFFSET_WIDTH];
        req_ctx.offset <= req_off;
        req_ctx.size   <= load_size_i;
        req_ctx.fault  <= req_fault;
    end

    assign rd.rd_stb  = rd_stb_q;
    assign rd.rd_addr = rd_addr_q;

    always_ff @(posedge clk) begin
        ctx_pipe[0] <= req_ctx;
        for (int i = 1; i < pkt_pkg::MEM_LAT; i++) begin
            ctx_pipe[i] <= ctx_pipe[i-1];
        end
    end

    assign ctx_out = ctx_pipe[pkt_pkg::MEM_LAT-1];

    // Offset byte moves to the top, counted from the MSB (big-endian)
    assign shifted  = rd.rd_data << {ctx_out.offset, 3'b000};
    assign selected = shifted[pkt_pkg::WORD_WIDTH-1 -: pkt_pkg::LOAD_WIDTH];

    // Smaller sizes are zero-padded on the left
    always_comb begin
        case (ctx_out.size)
            pkt_pkg::XFER_W: resized = selected;
            pkt_pkg::XFER_H: resized = {16'h0000, selected[31:16]};
            pkt_pkg::XFER_B: resized = {24'h000000, selected[31:24]};
            default:         resized = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            load_vld_o <= 1'b0;
        end else begin
            load_vld_o <= rd.rd_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (rd.rd_vld) begin
            load_data_o  <= ctx_out.fault ? '0 : resized;
            load_fault_o <= ctx_out.fault;
        end
    end

endmodule

`default_nettype wire

// ==== pkt_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module pkt_mem (
    input  wire logic                                clk,
    input  wire logic                                rst,

    // Write port, one 32-bit half per write
    input  wire logic                                wr_en_i,
    input  wire logic [1:0]                          wr_lane_i,
    input  wire logic [pkt_pkg::WORD_ADDR_WIDTH-1:0] wr_addr_i,
    input  wire logic [pkt_pkg::CAP_WIDTH-1:0]       wr_data_i,

    // Read port
    mem_rd_if.responder                              rd
);

    logic [pkt_pkg::WORD_WIDTH-1:0] mem [pkt_pkg::MEM_DEPTH];

    // First read stage and output register
    logic [pkt_pkg::WORD_WIDTH-1:0] ram_q;
    logic [pkt_pkg::WORD_WIDTH-1:0] out_q;

    // Valid follows the data through both stages
    logic [pkt_pkg::MEM_LAT-1:0]    vld_pipe;

    // Lane 0 is the upper half, lane 1 the lower half
    always_ff @(posedge clk) begin
        if (wr_en_i && wr_lane_i[0]) begin
            mem[wr_addr_i][pkt_pkg::WORD_WIDTH-1:pkt_pkg::CAP_WIDTH] <= wr_data_i;
        end
        if (wr_en_i && wr_lane_i[1]) begin
            mem[wr_addr_i][pkt_pkg::CAP_WIDTH-1:0] <= wr_data_i;
        end
    end

    // Same-word read in a write cycle sees the old contents
    always_ff @(posedge clk) begin
        if (rd.rd_stb) begin
            ram_q <= mem[rd.rd_addr];
        end
        if (vld_pipe[0]) begin
            out_q <= ram_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[pkt_pkg::MEM_LAT-2:0], rd.rd_stb};
        end
    end

    assign rd.rd_data = out_q;
    assign rd.rd_vld  = vld_pipe[pkt_pkg::MEM_LAT-1];

endmodule

`default_nettype wire

// ==== pkt_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module pkt_writer (
    input  wire logic                                clk,
    input  wire logic                                rst,

    // Capture stream
    input  wire logic                                cap_stb_i,
    input  wire logic [pkt_pkg::CAP_WIDTH-1:0]       cap_data_i,
    input  wire logic                                cap_end_i,

    // Write port of the packet memory
    output logic                                     wr_en_o,
    output logic [1:0]                               wr_lane_o,
    output logic [pkt_pkg::WORD_ADDR_WIDTH-1:0]      wr_addr_o,
    output logic [pkt_pkg::CAP_WIDTH-1:0]            wr_data_o,

    // Latched packet length in bytes
    output logic [pkt_pkg::PLEN_WIDTH-1:0]           byte_len_o
);

    // Count of 32-bit words written in the current packet
    logic [pkt_pkg::CAP_CNT_WIDTH-1:0] wr_cnt;

    // Word count including a final word that comes with the end strobe
    logic [pkt_pkg::CAP_CNT_WIDTH:0]   word_total;

    logic [pkt_pkg::PLEN_WIDTH-1:0]    byte_len_q;

    // Write goes out in the same cycle as the capture strobe
    assign wr_en_o   = cap_stb_i;
    assign wr_data_o = cap_data_i;

    // Upper count bits select the 64-bit memory word
    assign wr_addr_o = wr_cnt[pkt_pkg::CAP_CNT_WIDTH-1:1];

    // Even word goes to lane 0, the most significant half (big-endian)
    assign wr_lane_o = {wr_cnt[0], ~wr_cnt[0]};

    assign word_total = {1'b0, wr_cnt} + {{pkt_pkg::CAP_CNT_WIDTH{1'b0}}, cap_stb_i};

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_cnt <= '0;
        end else if (cap_end_i) begin
            // Next packet starts at address zero
            wr_cnt <= '0;
        end else if (cap_stb_i) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    // Length is four bytes per captured word, held until the next end strobe
    always_ff @(posedge clk) begin
        if (!rst) begin
            byte_len_q <= '0;
        end else if (cap_end_i) begin
            byte_len_q <= {
                {(pkt_pkg::PLEN_WIDTH - pkt_pkg::CAP_CNT_WIDTH - 3){1'b0}},
                word_total,
                2'b00
            };
        end
    end

    assign byte_len_o = byte_len_q;

endmodule

`default_nettype wire

// ==== mem_rd_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Read request and response between the load adapter and the packet RAM
interface mem_rd_if;

    // Request, one word read per strobe
    logic                                rd_stb;
    logic [pkt_pkg::WORD_ADDR_WIDTH-1:0] rd_addr;

    // Response, MEM_LAT edges after the strobe is sampled
    logic [pkt_pkg::WORD_WIDTH-1:0] rd_data;
    logic                           rd_vld;

    // Load adapter side
    modport requester (
        output rd_stb,
        output rd_addr,
        input  rd_data,
        input  rd_vld
    );

    // Packet memory side
    modport responder (
        input  rd_stb,
        input  rd_addr,
        output rd_data,
        output rd_vld
    );

endinterface

`default_nettype wire

// ==== pkt_pkg.sv ====
`default_nettype none

package pkt_pkg;

    // Packet memory holds 4096 bytes as 512 words of 64 bits
    localparam int unsigned BYTE_ADDR_WIDTH = 12;
    localparam int unsigned WORD_ADDR_WIDTH = 9;
    localparam int unsigned WORD_BYTES      = 8;
    localparam int unsigned WORD_WIDTH      = 64;
    localparam int unsigned OFFSET_WIDTH    = 3;
    localparam int unsigned MEM_DEPTH       = 512;

    // Capture side delivers 32-bit big-endian words
    localparam int unsigned CAP_WIDTH     = 32;
    localparam int unsigned CAP_CNT_WIDTH = WORD_ADDR_WIDTH + 1;

    // Byte length of the captured packet
    localparam int unsigned PLEN_WIDTH = 32;

    // Read strobe to read data, and load strobe to load result
    localparam int unsigned MEM_LAT  = 2;
    localparam int unsigned LOAD_LAT = 3;

    // Load result width, always one CPU word
    localparam int unsigned LOAD_WIDTH = 32;

    // Byte count of a load span inside one memory word, 0 to 8
    typedef logic [OFFSET_WIDTH:0] span_t;

    // Transfer size, BPF size-field order; value 3 is illegal
    typedef enum logic [1:0] {
        XFER_W = 2'd0,
        XFER_H = 2'd1,
        XFER_B = 2'd2
    } xfer_size_e;

endpackage

`default_nettype wire
